// File: src/nebula_bus_pkg.sv
// Nebula Wishbone bus definitions
package nebula_bus_pkg;

    localparam int unsigned WB_ADR_W = 32;
    localparam int unsigned WB_DAT_W = 32;
    localparam int unsigned WB_SEL_W = WB_DAT_W / 8;

    // Manager request held until ack
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_SEL_W-1:0] sel;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

    localparam wb_req_t WB_IDLE_REQ = '0;

    // Manager ids for round robin
    localparam int unsigned NUM_MANAGERS = 2;
    typedef logic [$clog2(NUM_MANAGERS)-1:0] mgr_id_t;
    localparam mgr_id_t MGR_HOST = mgr_id_t'(0);
    localparam mgr_id_t MGR_CPU  = mgr_id_t'(1);

    // Bus watchdog
    localparam int unsigned         WD_TIMEOUT_CYCLES = 16;
    localparam int unsigned         WD_CNT_W          = 5;
    localparam logic [WB_DAT_W-1:0] WD_TIMEOUT_DATA   = 32'hBAD0_BAD0;

endpackage

// File: src/nebula_map_pkg.sv
// Nebula address map and team output types
package nebula_map_pkg;

    localparam int unsigned NUM_TEAMS  = 4;
    localparam int unsigned TEAM_SEL_W = 3;
    localparam int unsigned TEAM_IDX_W = $clog2(NUM_TEAMS);

    // Region field sits in address bits 15..12
    localparam int unsigned REGION_LSB = 12;
    localparam int unsigned REGION_W   = 4;
    typedef logic [REGION_W-1:0] region_t;

    localparam region_t REGION_SRAM = region_t'(0);
    localparam region_t REGION_GPIO = region_t'(1);
    localparam region_t REGION_LA   = region_t'(2);

    localparam int unsigned SRAM_WORDS = 256;
    localparam int unsigned SRAM_ADR_W = $clog2(SRAM_WORDS);  // Word address from bit 2 up

    localparam int unsigned PAD_W = 38;
    localparam int unsigned LA_W  = 128;

    typedef struct packed {
        logic [PAD_W-1:0] out;
        logic [PAD_W-1:0] oeb;  // Active low output enable
    } gpio_pins_t;

    typedef logic [LA_W-1:0] la_word_t;

    localparam gpio_pins_t GPIO_DEFAULT = '{out: '0, oeb: '1};  // All pads as inputs
    localparam la_word_t   LA_DEFAULT   = '0;

    typedef gpio_pins_t [NUM_TEAMS-1:0] team_gpio_t;
    typedef la_word_t   [NUM_TEAMS-1:0] team_la_t;

endpackage

// File: src/wb_arbiter.sv
// Round-robin arbiter for two Wishbone managers
`timescale 1ns/10ps

module wb_arbiter (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  nebula_bus_pkg::wb_req_t host_req_i,
    input  nebula_bus_pkg::wb_req_t cpu_req_i,
    output nebula_bus_pkg::wb_rsp_t host_rsp_o,
    output nebula_bus_pkg::wb_rsp_t cpu_rsp_o,
    output nebula_bus_pkg::wb_req_t bus_req_o,
    input  nebula_bus_pkg::wb_rsp_t bus_rsp_i
);
    import nebula_bus_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        GRANT_HOST,
        GRANT_CPU
    } arb_state_t;

    arb_state_t state_q;
    arb_state_t state_d;
    mgr_id_t    last_q;  // Winner of the previous arbitration
    mgr_id_t    last_d;

    always_comb begin
        state_d = state_q;
        last_d  = last_q;
        case (state_q)
            IDLE: begin
                // On a tie the manager not granted last goes first
                if (host_req_i.cyc && (!cpu_req_i.cyc || last_q == MGR_CPU)) begin
                    state_d = GRANT_HOST;
                    last_d  = MGR_HOST;
                end else if (cpu_req_i.cyc) begin
                    state_d = GRANT_CPU;
                    last_d  = MGR_CPU;
                end
            end
            GRANT_HOST: begin
                if (!host_req_i.cyc) state_d = IDLE;  // Held for the whole cycle
            end
            GRANT_CPU: begin
                if (!cpu_req_i.cyc) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            last_q  <= MGR_CPU;  // Host wins the first tie
        end else begin
            state_q <= state_d;
            last_q  <= last_d;
        end
    end

    // Request and response steering
    always_comb begin
        bus_req_o  = WB_IDLE_REQ;
        host_rsp_o = '0;
        cpu_rsp_o  = '0;
        case (state_q)
            GRANT_HOST: begin
                bus_req_o  = host_req_i;
                host_rsp_o = bus_rsp_i;
            end
            GRANT_CPU: begin
                bus_req_o = cpu_req_i;
                cpu_rsp_o = bus_rsp_i;
            end
            default: ;
        endcase
    end

endmodule

// File: src/wb_watchdog.sv
// Bus watchdog for unacknowledged transfers
`timescale 1ns/10ps

module wb_watchdog (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  nebula_bus_pkg::wb_req_t bus_req_i,
    input  nebula_bus_pkg::wb_rsp_t dec_rsp_i,
    output nebula_bus_pkg::wb_rsp_t bus_rsp_o
);
    import nebula_bus_pkg::*;

    logic [WD_CNT_W-1:0] cnt_q;  // Cycles of stb without ack
    logic                active;
    logic                timeout;

    assign active  = bus_req_i.cyc & bus_req_i.stb;
    assign timeout = active && (cnt_q == WD_CNT_W'(WD_TIMEOUT_CYCLES));

    // Substitute an error ack once the limit is hit
    always_comb begin
        if (timeout) begin
            bus_rsp_o.ack = 1'b1;
            bus_rsp_o.dat = WD_TIMEOUT_DATA;
        end else begin
            bus_rsp_o = dec_rsp_i;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (!active || bus_rsp_o.ack) begin
            cnt_q <= '0;  // Also clears after our own ack
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

// File: src/wb_decoder.sv
// Wishbone address decoder for the nebula peripherals
`timescale 1ns/10ps

module wb_decoder (
    input  nebula_bus_pkg::wb_req_t bus_req_i,
    output nebula_bus_pkg::wb_req_t sram_req_o,
    output nebula_bus_pkg::wb_req_t gpio_req_o,
    output nebula_bus_pkg::wb_req_t la_req_o,
    input  nebula_bus_pkg::wb_rsp_t sram_rsp_i,
    input  nebula_bus_pkg::wb_rsp_t gpio_rsp_i,
    input  nebula_bus_pkg::wb_rsp_t la_rsp_i,
    output nebula_bus_pkg::wb_rsp_t dec_rsp_o
);
    import nebula_bus_pkg::*;
    import nebula_map_pkg::*;

    region_t region;
    logic    hit_sram;
    logic    hit_gpio;
    logic    hit_la;

    // Only the selected peripheral sees cyc and stb
    function automatic wb_req_t gate_req(input wb_req_t req, input logic hit);
        wb_req_t gated;
        gated     = req;
        gated.cyc = req.cyc & hit;
        gated.stb = req.stb & hit;
        return gated;
    endfunction

    assign region   = bus_req_i.adr[REGION_LSB +: REGION_W];
    assign hit_sram = (region == REGION_SRAM);
    assign hit_gpio = (region == REGION_GPIO);
    assign hit_la   = (region == REGION_LA);

    assign sram_req_o = gate_req(bus_req_i, hit_sram);
    assign gpio_req_o = gate_req(bus_req_i, hit_gpio);
    assign la_req_o   = gate_req(bus_req_i, hit_la);

    // Response mux back toward the arbiter
    always_comb begin
        case (region)
            REGION_SRAM: dec_rsp_o = sram_rsp_i;
            REGION_GPIO: dec_rsp_o = gpio_rsp_i;
            REGION_LA:   dec_rsp_o = la_rsp_i;
            default:     dec_rsp_o = '0;  // Unmapped so the watchdog ends it
        endcase
    end

endmodule

// File: src/wb_sram.sv
// 256x32 Wishbone SRAM with byte selects
`timescale 1ns/10ps

module wb_sram (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  nebula_bus_pkg::wb_req_t req_i,
    output nebula_bus_pkg::wb_rsp_t rsp_o
);
    import nebula_bus_pkg::*;
    import nebula_map_pkg::*;

    logic [WB_DAT_W-1:0]   mem [SRAM_WORDS];
    logic [WB_DAT_W-1:0]   rdata_q;
    logic [SRAM_ADR_W-1:0] word_adr;
    logic                  ack_q;
    logic                  access;

    assign word_adr = req_i.adr[SRAM_ADR_W+1:2];
    assign access   = req_i.cyc & req_i.stb & ~ack_q;  // One ack per transfer

    // Memory array and read register
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            if (req_i.we) begin
                for (int b = 0; b < WB_SEL_W; b++) begin
                    if (req_i.sel[b]) begin
                        mem[word_adr][8*b +: 8] <= req_i.dat[8*b +: 8];
                    end
                end
            end
            rdata_q <= mem[word_adr];  // Old word on a write
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

endmodule

// File: src/team_output_select.sv
// Team select register and output multiplexer
`timescale 1ns/10ps

module team_output_select #(
    parameter type      payload_t     = nebula_map_pkg::la_word_t,
    parameter payload_t DEFAULT_VALUE = '0,
    parameter type      team_arr_t    = payload_t [nebula_map_pkg::NUM_TEAMS-1:0]
) (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  nebula_bus_pkg::wb_req_t req_i,
    output nebula_bus_pkg::wb_rsp_t rsp_o,
    input  team_arr_t               team_out_i,
    output payload_t                sel_out_o
);
    import nebula_bus_pkg::*;
    import nebula_map_pkg::*;

    logic [TEAM_SEL_W-1:0] sel_q;   // 0 means no team
    logic [TEAM_SEL_W-1:0] sel_m1;
    logic                  sel_valid;
    logic                  ack_q;
    logic                  access;
    logic                  wr_en;

    assign access = req_i.cyc & req_i.stb & ~ack_q;
    assign wr_en  = access & req_i.we & req_i.sel[0];  // Field lives in byte 0

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            sel_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
            if (wr_en) begin
                sel_q <= req_i.dat[TEAM_SEL_W-1:0];
            end
        end
    end

    // Readback is the zero-extended select value
    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = WB_DAT_W'(sel_q);

    // Select n drives team n-1
    assign sel_m1    = sel_q - 1'b1;
    assign sel_valid = (sel_q != '0) && (sel_q <= TEAM_SEL_W'(NUM_TEAMS));

    always_comb begin
        if (sel_valid) begin
            sel_out_o = team_out_i[sel_m1[TEAM_IDX_W-1:0]];
        end else begin
            sel_out_o = DEFAULT_VALUE;  // Out of range falls back too
        end
    end

endmodule

// File: src/nebula_top.sv
// Nebula multi-team user area top level
`timescale 1ns/10ps

module nebula_top (
    input  logic                         wb_clk_i,
    input  logic                         rst_n_i,
    input  nebula_bus_pkg::wb_req_t      host_req_i,
    input  nebula_bus_pkg::wb_req_t      cpu_req_i,
    output nebula_bus_pkg::wb_rsp_t      host_rsp_o,
    output nebula_bus_pkg::wb_rsp_t      cpu_rsp_o,
    input  nebula_map_pkg::team_gpio_t   team_gpio_i,
    input  nebula_map_pkg::team_la_t     team_la_i,
    output logic [37:0]                  io_out_o,
    output logic [37:0]                  io_oeb_o,
    output nebula_map_pkg::la_word_t     la_data_out_o
);
    nebula_bus_pkg::wb_req_t    bus_req;   // Granted manager
    nebula_bus_pkg::wb_rsp_t    bus_rsp;   // After the watchdog
    nebula_bus_pkg::wb_rsp_t    dec_rsp;
    nebula_bus_pkg::wb_req_t    sram_req;
    nebula_bus_pkg::wb_rsp_t    sram_rsp;
    nebula_bus_pkg::wb_req_t    gpio_req;
    nebula_bus_pkg::wb_rsp_t    gpio_rsp;
    nebula_bus_pkg::wb_req_t    la_req;
    nebula_bus_pkg::wb_rsp_t    la_rsp;
    nebula_map_pkg::gpio_pins_t gpio_pins;

    wb_arbiter arbiter (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .host_req_i (host_req_i),
        .cpu_req_i  (cpu_req_i),
        .host_rsp_o (host_rsp_o),
        .cpu_rsp_o  (cpu_rsp_o),
        .bus_req_o  (bus_req),
        .bus_rsp_i  (bus_rsp)
    );

    wb_watchdog watchdog (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .bus_req_i (bus_req),
        .dec_rsp_i (dec_rsp),
        .bus_rsp_o (bus_rsp)
    );

    wb_decoder decoder (
        .bus_req_i  (bus_req),
        .sram_req_o (sram_req),
        .gpio_req_o (gpio_req),
        .la_req_o   (la_req),
        .sram_rsp_i (sram_rsp),
        .gpio_rsp_i (gpio_rsp),
        .la_rsp_i   (la_rsp),
        .dec_rsp_o  (dec_rsp)
    );

    wb_sram sram (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .req_i    (sram_req),
        .rsp_o    (sram_rsp)
    );

    // Pad ownership
    team_output_select #(
        .payload_t     (nebula_map_pkg::gpio_pins_t),
        .DEFAULT_VALUE (nebula_map_pkg::GPIO_DEFAULT),
        .team_arr_t    (nebula_map_pkg::team_gpio_t)
    ) gpio_select (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (gpio_req),
        .rsp_o      (gpio_rsp),
        .team_out_i (team_gpio_i),
        .sel_out_o  (gpio_pins)
    );

    // Logic analyzer ownership
    team_output_select #(
        .payload_t     (nebula_map_pkg::la_word_t),
        .DEFAULT_VALUE (nebula_map_pkg::LA_DEFAULT),
        .team_arr_t    (nebula_map_pkg::team_la_t)
    ) la_select (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (la_req),
        .rsp_o      (la_rsp),
        .team_out_i (team_la_i),
        .sel_out_o  (la_data_out_o)
    );

    assign io_out_o = gpio_pins.out;
    assign io_oeb_o = gpio_pins.oeb;

endmodule

// File: verification/nebula_props.sv
// Arbiter grant properties
`timescale 1ns/10ps

module nebula_props (
    input logic                    wb_clk_i,
    input logic                    rst_n_i,
    input nebula_bus_pkg::wb_req_t host_req_i,
    input nebula_bus_pkg::wb_req_t cpu_req_i,
    input nebula_bus_pkg::wb_rsp_t host_rsp_i,
    input nebula_bus_pkg::wb_rsp_t cpu_rsp_i,
    input nebula_bus_pkg::wb_req_t bus_req_i,
    input logic [1:0]              state_i
);
    import nebula_bus_pkg::*;

    localparam logic [1:0] ST_HOST = 2'd1;  // Arbiter state encoding
    localparam logic [1:0] ST_CPU  = 2'd2;

    int fail_count = 0;  // Failed properties so far

    // Acks only reach the granted manager
    host_ack_granted: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        host_rsp_i.ack |-> state_i == ST_HOST)
        else begin
            $error("host ack seen without a host grant");
            fail_count++;
        end
    cpu_ack_granted: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        cpu_rsp_i.ack |-> state_i == ST_CPU)
        else begin
            $error("cpu ack seen without a cpu grant");
            fail_count++;
        end

    bus_idle_no_cyc: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        (!host_req_i.cyc && !cpu_req_i.cyc) |-> bus_req_i == WB_IDLE_REQ)
        else begin
            $error("bus request not idle while no manager holds cyc");
            fail_count++;
        end

    // Grant is kept for the whole bus cycle
    host_grant_held: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        (state_i == ST_HOST && host_req_i.cyc) |=> state_i == ST_HOST)
        else begin
            $error("host lost its grant while cyc was high");
            fail_count++;
        end
    cpu_grant_held: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        (state_i == ST_CPU && cpu_req_i.cyc) |=> state_i == ST_CPU)
        else begin
            $error("cpu lost its grant while cyc was high");
            fail_count++;
        end

endmodule

bind wb_arbiter nebula_props arbiter_props (
    .wb_clk_i   (wb_clk_i),
    .rst_n_i    (rst_n_i),
    .host_req_i (host_req_i),
    .cpu_req_i  (cpu_req_i),
    .host_rsp_i (host_rsp_o),
    .cpu_rsp_i  (cpu_rsp_o),
    .bus_req_i  (bus_req_o),
    .state_i    (state_q)
);

// File: verification/nebula_tb.sv
// Nebula user area testbench
`timescale 1ns/10ps

module nebula_tb;
    import nebula_bus_pkg::*;
    import nebula_map_pkg::*;

    localparam int ACK_TIMEOUT  = 60;     // Cycles per transfer including contention
    localparam int GLOBAL_LIMIT = 20000;

    logic       clk;
    logic       rst_n;
    wb_req_t    host_req;
    wb_req_t    cpu_req;
    wb_rsp_t    host_rsp;
    wb_rsp_t    cpu_rsp;
    team_gpio_t team_gpio;
    team_la_t   team_la;
    logic [37:0] io_out;
    logic [37:0] io_oeb;
    la_word_t   la_data_out;

    logic [31:0]  sram_model [256];
    string        name_q [$];
    logic [127:0] exp_q [$];
    logic [127:0] act_q [$];
    int           check_count   = 0;
    int           error_count   = 0;
    int           timeout_count = 0;

    nebula_top dut (
        .wb_clk_i      (clk),
        .rst_n_i       (rst_n),
        .host_req_i    (host_req),
        .cpu_req_i     (cpu_req),
        .host_rsp_o    (host_rsp),
        .cpu_rsp_o     (cpu_rsp),
        .team_gpio_i   (team_gpio),
        .team_la_i     (team_la),
        .io_out_o      (io_out),
        .io_oeb_o      (io_oeb),
        .la_data_out_o (la_data_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reference models
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] sel);
        logic [31:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic logic [31:0] word_addr(input logic [7:0] word);
        return {16'h0, REGION_SRAM, 2'b00, word, 2'b00};
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] adr);
        return sram_model[adr[9:2]];
    endfunction

    function automatic gpio_pins_t expected_gpio(input int sel);
        logic [1:0] idx;
        idx = 2'(sel - 1);
        if (sel >= 1 && sel <= NUM_TEAMS) return team_gpio[idx];
        return GPIO_DEFAULT;  // No team owns the pads
    endfunction

    function automatic la_word_t expected_la(input int sel);
        logic [1:0] idx;
        idx = 2'(sel - 1);
        if (sel >= 1 && sel <= NUM_TEAMS) return team_la[idx];
        return '0;
    endfunction

    function automatic void post_check(input string name, input logic [127:0] exp_v,
                                       input logic [127:0] act_v);
        name_q.push_back(name);
        exp_q.push_back(exp_v);
        act_q.push_back(act_v);
    endfunction

    // Compare process
    always @(negedge clk) begin : compare
        string        name;
        logic [127:0] exp_v;
        logic [127:0] act_v;
        while (name_q.size() > 0) begin
            name  = name_q.pop_front();
            exp_v = exp_q.pop_front();
            act_v = act_q.pop_front();
            check_count++;
            assert (act_v === exp_v) else begin
                error_count++;
                $display("CHECK FAILED at %0t: %s = %0h, expected %0h",
                         $time, name, act_v, exp_v);
            end
        end
    end

    // Called and returns 2 ns after a rising edge
    task automatic bus_transfer(input bit use_cpu, input logic we, input logic [3:0] sel,
                                input logic [31:0] adr, input logic [31:0] wdat,
                                output logic [31:0] rdat);
        wb_req_t req;
        wb_rsp_t rsp;
        int      cycles;
        req    = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: wdat};
        rdat   = '0;
        cycles = 0;
        if (use_cpu) cpu_req = req;
        else host_req = req;
        do begin
            @(posedge clk);
            #1;
            rsp = use_cpu ? cpu_rsp : host_rsp;
            cycles++;
        end while (!rsp.ack && cycles < ACK_TIMEOUT);
        if (rsp.ack) begin
            rdat = rsp.dat;
        end else begin
            timeout_count++;
            $display("ERROR at %0t: transfer to %h on the %s port got no ack",
                     $time, adr, use_cpu ? "cpu" : "host");
        end
        #1;
        if (use_cpu) cpu_req = WB_IDLE_REQ;
        else host_req = WB_IDLE_REQ;
        @(posedge clk);  // One idle cycle lets the arbiter rotate
        #2;
    endtask

    task automatic sram_write(input bit use_cpu, input logic [7:0] word,
                              input logic [3:0] sel, input logic [31:0] data);
        logic [31:0] old_data;
        bus_transfer(use_cpu, 1'b1, sel, word_addr(word), data, old_data);
        sram_model[word] = merge_bytes(sram_model[word], data, sel);
    endtask

    task automatic sram_read_check(input bit use_cpu, input logic [7:0] word);
        logic [31:0] rdat;
        bus_transfer(use_cpu, 1'b0, 4'hF, word_addr(word), 32'h0, rdat);
        post_check(use_cpu ? "cpu_rsp_o.dat" : "host_rsp_o.dat",
                   128'(expected_read(word_addr(word))), 128'(rdat));
    endtask

    task automatic mixed_traffic(input bit use_cpu, input int count);
        logic [7:0] word;
        for (int i = 0; i < count; i++) begin
            word = {use_cpu, 7'($urandom())};  // Each manager keeps its own half
            sram_write(use_cpu, word, 4'hF, $urandom());
            sram_write(use_cpu, word, 4'($urandom()), $urandom());
            sram_read_check(use_cpu, word);
        end
    endtask

    task automatic team_select_sweep(input bit use_cpu, input region_t region,
                                     input bit is_gpio);
        logic [31:0] rdat;
        logic [31:0] adr;
        gpio_pins_t  exp_gpio;
        adr = {16'h0, region, 12'h000};
        for (int v = 0; v < 8; v++) begin
            bus_transfer(use_cpu, 1'b1, 4'h1, adr, 32'(v), rdat);
            bus_transfer(use_cpu, 1'b0, 4'hF, adr, 32'h0, rdat);
            post_check(is_gpio ? "gpio select readback" : "la select readback",
                       128'(v), 128'(rdat));
            if (is_gpio) begin
                exp_gpio = expected_gpio(v);
                post_check("io_out_o", 128'(exp_gpio.out), 128'(io_out));
                post_check("io_oeb_o", 128'(exp_gpio.oeb), 128'(io_oeb));
            end else begin
                post_check("la_data_out_o", expected_la(v), la_data_out);
            end
        end
    endtask

    initial begin
        repeat (GLOBAL_LIMIT) @(posedge clk);
        $display("ERROR: run did not finish within %0d cycles", GLOBAL_LIMIT);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [63:0] rnd;
        logic [1:0]  idx;
        logic [7:0]  words [12];
        logic [31:0] rdat;
        int          drain;
        int          assert_fails;
        void'($urandom(32'h04e2_9fdb));
        rst_n    = 1'b0;
        host_req = WB_IDLE_REQ;
        cpu_req  = WB_IDLE_REQ;
        for (int t = 0; t < NUM_TEAMS; t++) begin
            idx = 2'(t);
            rnd = {$urandom(), $urandom()};
            team_gpio[idx].out = rnd[37:0];
            rnd = {$urandom(), $urandom()};
            team_gpio[idx].oeb = rnd[37:0];
            team_la[idx] = {$urandom(), $urandom(), $urandom(), $urandom()};
        end
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;

        // State right after reset
        @(posedge clk);
        #1;
        post_check("host_rsp_o.ack", 128'(0), 128'(host_rsp.ack));
        post_check("cpu_rsp_o.ack", 128'(0), 128'(cpu_rsp.ack));
        post_check("io_oeb_o", 128'({38{1'b1}}), 128'(io_oeb));
        post_check("io_out_o", 128'(0), 128'(io_out));
        post_check("la_data_out_o", 128'(0), la_data_out);
        #1;

        // Byte-merged writes then reads from the host
        for (int i = 0; i < 12; i++) begin
            words[i] = 8'($urandom());
            sram_write(1'b0, words[i], 4'hF, $urandom());
            sram_write(1'b0, words[i], 4'($urandom()), $urandom());
        end
        for (int i = 0; i < 12; i++) sram_read_check(1'b0, words[i]);

        fork
            mixed_traffic(1'b0, 10);
            mixed_traffic(1'b1, 10);
        join

        team_select_sweep(1'b0, REGION_GPIO, 1'b1);
        team_select_sweep(1'b1, REGION_LA, 1'b0);

        // Unmapped region then an SRAM read
        bus_transfer(1'b0, 1'b0, 4'hF, {16'h0, 4'h5, 12'h000}, 32'h0, rdat);
        post_check("host_rsp_o.dat", 128'(WD_TIMEOUT_DATA), 128'(rdat));
        sram_read_check(1'b0, words[0]);

        drain = 0;
        while (name_q.size() > 0 && drain < 10) begin
            @(posedge clk);
            drain++;
        end
        if (name_q.size() > 0) begin
            $display("ERROR: %0d checks were never compared", name_q.size());
            error_count++;
        end
        assert_fails = dut.arbiter.arbiter_props.fail_count;
        $display("Checks: %0d, check errors: %0d, transfer timeouts: %0d, assertion failures: %0d",
                 check_count, error_count, timeout_count, assert_fails);
        if (error_count == 0 && timeout_count == 0 && assert_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: nebula.f
src/nebula_bus_pkg.sv
src/nebula_map_pkg.sv
src/wb_arbiter.sv
src/wb_watchdog.sv
src/wb_decoder.sv
src/wb_sram.sv
src/team_output_select.sv
src/nebula_top.sv
verification/nebula_props.sv
verification/nebula_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the nebula testbench with Verilator, run it, and judge the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module nebula_tb -f nebula.f -o nebula_sim \
    > build.log 2>&1 \
    && ./obj_dir/nebula_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
